//--- Makefile
# Verilator simulation of the pipeline core

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f pipeline_core.f --top-module tb_pipeline_core -o sim
	./obj_dir/sim | tee $(LOG)
	grep -qx "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- pipeline_core.f
verilog/mips_pkg.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/pipeline_core.sv
tb/tb_pipeline_core.sv

//--- tb/tb_pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_core;
    import mips_pkg::*;

    // roughly 1200 cycles of tests plus margin
    localparam int max_cycles = 3000;

    // chain operations starting at entry 0
    localparam logic [6:0][5:0] chain_fn =
        {fn_and, fn_or, fn_slt, fn_nor, fn_xor, fn_sub, fn_add};

    logic  clk;
    logic  rst_n;
    logic  instr_valid;
    word_t instr;
    wb_t   wb;

    word_t       model_regs [32];
    wb_t         exp_q [$];
    int          exp_cycle [$];
    int          cycles;
    int          error_count;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;
    string       test_name;
    logic [31:0] lfsr;

    pipeline_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // outputs are sampled half a cycle after they change
    always @(negedge clk) begin
        if (wb.valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write-back to r%0d during test %s", wb.idx, test_name);
                error_count++;
            end else begin
                check("index", 32'(exp_q[0].idx), 32'(wb.idx));
                check("data", exp_q[0].data, wb.data);
                check("arrival cycle", exp_cycle[0], cycles);
                void'(exp_q.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t rtype(input logic [5:0] fn, input reg_idx_t rd,
                                    input reg_idx_t rs, input reg_idx_t rt,
                                    input logic [4:0] sh);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input reg_idx_t rt,
                                    input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic apply_model(input word_t w);
        logic [5:0] opcode;
        logic [5:0] fn;
        reg_idx_t   dest;
        word_t      a;
        word_t      b;
        word_t      se;
        word_t      ze;
        word_t      res;
        logic       known;
        opcode = w[31:26];
        fn     = w[5:0];
        a      = model_regs[w[25:21]];
        b      = model_regs[w[20:16]];
        se     = {{16{w[15]}}, w[15:0]};
        ze     = {16'h0000, w[15:0]};
        dest   = w[20:16];
        known  = 1'b1;
        res    = '0;
        case (opcode)
            op_rtype: begin
                dest = w[15:11];
                case (fn)
                    fn_add:  res = a + b;
                    fn_sub:  res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_nor:  res = ~(a | b);
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sll:  res = b << w[10:6];
                    fn_srl:  res = b >> w[10:6];
                    fn_sra:  res = $signed(b) >>> w[10:6];
                    default: known = 1'b0;
                endcase
            end
            op_addi: res = a + se;
            op_slti: res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            op_andi: res = a & ze;
            op_ori:  res = a | ze;
            op_xori: res = a ^ ze;
            op_lui:  res = {w[15:0], 16'h0000};
            default: known = 1'b0;
        endcase
        // record leaves wb three edges after acceptance
        if (known && dest != 5'd0) begin
            model_regs[dest] = res;
            exp_q.push_back('{valid: 1'b1, idx: dest, data: res});
            exp_cycle.push_back(cycles + 3);
        end
    endtask

    task automatic issue(input word_t w);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        apply_model(w);
    endtask

    task automatic issue_invalid(input word_t w);
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = w;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        // fixed three-cycle latency drains the pipeline within four cycles
        idle(4);
        check("queue depth", 32'd0, 32'(exp_q.size()));
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
            fail_count++;
        end
    endtask

    function automatic word_t random_instr(input logic [3:0] kind, input reg_idx_t rd,
                                           input reg_idx_t rs, input reg_idx_t rt,
                                           input logic [4:0] sh, input logic [15:0] imm);
        case (kind)
            4'd0:    return rtype(fn_add, rd, rs, rt, 5'd0);
            4'd1:    return rtype(fn_sub, rd, rs, rt, 5'd0);
            4'd2:    return rtype(fn_and, rd, rs, rt, 5'd0);
            4'd3:    return rtype(fn_or, rd, rs, rt, 5'd0);
            4'd4:    return rtype(fn_xor, rd, rs, rt, 5'd0);
            4'd5:    return rtype(fn_nor, rd, rs, rt, 5'd0);
            4'd6:    return rtype(fn_slt, rd, rs, rt, 5'd0);
            4'd7:    return rtype(fn_sll, rd, 5'd0, rt, sh);
            4'd8:    return rtype(fn_srl, rd, 5'd0, rt, sh);
            4'd9:    return rtype(fn_sra, rd, 5'd0, rt, sh);
            4'd10:   return itype(op_addi, rt, rs, imm);
            4'd11:   return itype(op_slti, rt, rs, imm);
            4'd12:   return itype(op_andi, rt, rs, imm);
            4'd13:   return itype(op_ori, rt, rs, imm);
            4'd14:   return itype(op_xori, rt, rs, imm);
            default: return itype(op_lui, rt, 5'd0, imm);
        endcase
    endfunction

    task automatic random_stream(input int count);
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] sh;
        logic [31:0] imm;
        logic [31:0] gap;
        for (int n = 0; n < count; n++) begin
            draw(4, kind);
            draw(3, rd);
            draw(3, rs);
            draw(3, rt);
            draw(5, sh);
            draw(16, imm);
            draw(2, gap);
            issue(random_instr(kind[3:0], rd[4:0], rs[4:0], rt[4:0], sh[4:0], imm[15:0]));
            idle(gap);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'h5da7;
        cycles      = 0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        start_test("reset");
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(3);
        issue(itype(op_addi, 5'd1, 5'd0, 16'd5));
        finish_test();

        // gap 0 uses mem forwarding, gap 1 wb forwarding, gap 2 the bypass
        start_test("dependent chain");
        issue(itype(op_addi, 5'd1, 5'd0, 16'd3));
        issue(itype(op_lui, 5'd2, 5'd0, 16'hbeef));
        for (int gap = 0; gap < 3; gap++) begin
            for (int i = 0; i < 7; i++) begin
                issue(rtype(chain_fn[i], reg_idx_t'((i + 2) % 7 + 1),
                            reg_idx_t'((i + 1) % 7 + 1), reg_idx_t'(i % 7 + 1), 5'd0));
                idle(gap);
            end
        end
        finish_test();

        start_test("immediates");
        issue(itype(op_addi, 5'd1, 5'd0, 16'hffff));
        issue(itype(op_addi, 5'd2, 5'd1, 16'h8000));
        issue(itype(op_slti, 5'd3, 5'd1, 16'h0001));
        issue(itype(op_slti, 5'd4, 5'd2, 16'hfff0));
        issue(itype(op_andi, 5'd5, 5'd1, 16'hf0f0));
        issue(itype(op_ori, 5'd6, 5'd0, 16'h8001));
        issue(itype(op_xori, 5'd7, 5'd1, 16'hffff));
        issue(itype(op_lui, 5'd1, 5'd0, 16'h8765));
        issue(itype(op_ori, 5'd1, 5'd1, 16'h4321));
        finish_test();

        start_test("shifts and compare");
        issue(itype(op_lui, 5'd1, 5'd0, 16'h8000));
        issue(itype(op_ori, 5'd1, 5'd1, 16'h00f1));
        issue(rtype(fn_sll, 5'd2, 5'd0, 5'd1, 5'd0));
        issue(rtype(fn_sll, 5'd2, 5'd0, 5'd1, 5'd31));
        issue(rtype(fn_srl, 5'd3, 5'd0, 5'd1, 5'd0));
        issue(rtype(fn_srl, 5'd3, 5'd0, 5'd1, 5'd31));
        issue(rtype(fn_sra, 5'd4, 5'd0, 5'd1, 5'd0));
        issue(rtype(fn_sra, 5'd4, 5'd0, 5'd1, 5'd31));
        issue(rtype(fn_sra, 5'd4, 5'd0, 5'd1, 5'd4));
        issue(itype(op_addi, 5'd3, 5'd0, 16'hfffb));
        issue(itype(op_addi, 5'd4, 5'd0, 16'd7));
        issue(rtype(fn_slt, 5'd5, 5'd3, 5'd4, 5'd0));
        issue(rtype(fn_slt, 5'd6, 5'd4, 5'd3, 5'd0));
        issue(itype(op_slti, 5'd7, 5'd3, 16'hfffd));
        issue(itype(op_slti, 5'd7, 5'd4, 16'hfffd));
        finish_test();

        start_test("no-write cases");
        issue(rtype(fn_add, 5'd0, 5'd1, 5'd2, 5'd0));
        issue(itype(op_addi, 5'd0, 5'd1, 16'd5));
        issue(itype(6'h3f, 5'd1, 5'd2, 16'h1234));
        issue(rtype(6'h01, 5'd1, 5'd2, 5'd3, 5'd0));
        issue_invalid(itype(op_addi, 5'd1, 5'd0, 16'd1));
        issue_invalid(rtype(fn_add, 5'd2, 5'd1, 5'd1, 5'd0));
        issue(rtype(fn_or, 5'd2, 5'd0, 5'd0, 5'd0));
        issue(rtype(fn_add, 5'd3, 5'd1, 5'd0, 5'd0));
        finish_test();

        start_test("random stream");
        random_stream(400);
        finish_test();

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (error_count == 0 && fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_e                  op,
    input  mips_pkg::word_t                    a,
    input  mips_pkg::word_t                    b,
    input  logic [mips_pkg::shamt_width-1:0]   shamt,
    output mips_pkg::word_t                    result
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_nor: begin
                result = ~(a | b);
            end
            // signed compare
            alu_slt: begin
                result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            end
            // shifts act on b only
            alu_sll: begin
                result = b << shamt;
            end
            alu_srl: begin
                result = b >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(b) >>> shamt);
            end
            alu_lui: begin
                result = {b[imm_width-1:0], {(word_width-imm_width){1'b0}}};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output mips_pkg::wb_t      wb
);
    import mips_pkg::*;

    decoded_t ex_dec;
    logic     ex_we;
    word_t    ex_rs_data;
    word_t    ex_rt_data;
    word_t    op_a;
    word_t    rt_fwd;
    word_t    op_b;
    word_t    alu_result;
    wb_t      mem_q;

    // id/ex payload
    always_ff @(posedge clk) begin
        ex_dec     <= dec;
        ex_rs_data <= rs_data;
        ex_rt_data <= rt_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_we <= 1'b0;
        else
            ex_we <= dec.write_en;
    end

    // newer producer wins
    function automatic word_t forward(input reg_idx_t idx, input word_t rf_val);
        if (mem_q.valid && mem_q.idx == idx)
            return mem_q.data;
        else if (wb.valid && wb.idx == idx)
            return wb.data;
        else
            return rf_val;
    endfunction

    always_comb begin
        op_a   = forward(ex_dec.rs, ex_rs_data);
        rt_fwd = forward(ex_dec.rt, ex_rt_data);
    end

    assign op_b = ex_dec.use_imm ? ex_dec.imm : rt_fwd;

    alu alu (
        .op     (ex_dec.alu_op),
        .a      (op_a),
        .b      (op_b),
        .shamt  (ex_dec.shamt),
        .result (alu_result)
    );

    // ex/mem feeds mem/wb which is the output record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_q <= '0;
            wb    <= '0;
        end else begin
            mem_q <= '{valid: ex_we, idx: ex_dec.dest, data: alu_result};
            wb    <= mem_q;
        end
    end

    wb_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(wb.valid)
    );

    wb_idx_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) wb.valid |-> wb.idx != '0
    );

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic               instr_valid,
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    logic [opcode_width-1:0] opcode;
    logic [funct_width-1:0]  funct;
    logic [imm_width-1:0]    imm;
    logic [shamt_width-1:0]  shamt;
    reg_idx_t                rs;
    reg_idx_t                rt;
    reg_idx_t                rd;
    reg_idx_t                dest;
    alu_op_e                 op;
    logic                    known;
    logic                    use_imm;
    logic                    sign_ext;
    word_t                   imm_ext;

    // field slicing
    assign opcode = instr[word_width-1 -: opcode_width];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[funct_width-1:0];
    assign imm    = instr[imm_width-1:0];

    always_comb begin
        known    = 1'b1;
        op       = alu_add;
        dest     = rt;
        use_imm  = 1'b1;
        sign_ext = 1'b1;
        case (opcode)
            op_rtype: begin
                dest    = rd;
                use_imm = 1'b0;
                case (funct)
                    fn_add:  op = alu_add;
                    fn_sub:  op = alu_sub;
                    fn_and:  op = alu_and;
                    fn_or:   op = alu_or;
                    fn_xor:  op = alu_xor;
                    fn_nor:  op = alu_nor;
                    fn_slt:  op = alu_slt;
                    fn_sll:  op = alu_sll;
                    fn_srl:  op = alu_srl;
                    fn_sra:  op = alu_sra;
                    default: known = 1'b0;
                endcase
            end
            op_addi: op = alu_add;
            op_slti: op = alu_slt;
            // logical immediates are zero extended
            op_andi: begin
                op       = alu_and;
                sign_ext = 1'b0;
            end
            op_ori: begin
                op       = alu_or;
                sign_ext = 1'b0;
            end
            op_xori: begin
                op       = alu_xor;
                sign_ext = 1'b0;
            end
            op_lui: begin
                op       = alu_lui;
                sign_ext = 1'b0;
            end
            default: known = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{(word_width-imm_width){imm[imm_width-1]}}, imm}
                              : {{(word_width-imm_width){1'b0}}, imm};

    // unknown codes, r0 targets and bubbles never write
    assign dec = '{alu_op:   op,
                   rs:       rs,
                   rt:       rt,
                   dest:     dest,
                   write_en: instr_valid && known && (dest != '0),
                   use_imm:  use_imm,
                   imm:      imm_ext,
                   shamt:    shamt};

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // widths
    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;
    localparam int opcode_width   = 6;
    localparam int funct_width    = 6;
    localparam int shamt_width    = 5;
    localparam int imm_width      = 16;

    // opcodes
    localparam logic [opcode_width-1:0] op_rtype = 6'h00;
    localparam logic [opcode_width-1:0] op_addi  = 6'h08;
    localparam logic [opcode_width-1:0] op_slti  = 6'h0a;
    localparam logic [opcode_width-1:0] op_andi  = 6'h0c;
    localparam logic [opcode_width-1:0] op_ori   = 6'h0d;
    localparam logic [opcode_width-1:0] op_xori  = 6'h0e;
    localparam logic [opcode_width-1:0] op_lui   = 6'h0f;

    // r-type function codes
    localparam logic [funct_width-1:0] fn_sll = 6'h00;
    localparam logic [funct_width-1:0] fn_srl = 6'h02;
    localparam logic [funct_width-1:0] fn_sra = 6'h03;
    localparam logic [funct_width-1:0] fn_add = 6'h20;
    localparam logic [funct_width-1:0] fn_sub = 6'h22;
    localparam logic [funct_width-1:0] fn_and = 6'h24;
    localparam logic [funct_width-1:0] fn_or  = 6'h25;
    localparam logic [funct_width-1:0] fn_xor = 6'h26;
    localparam logic [funct_width-1:0] fn_nor = 6'h27;
    localparam logic [funct_width-1:0] fn_slt = 6'h2a;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // one decoded instruction
    typedef struct packed {
        alu_op_e                alu_op;
        reg_idx_t               rs;
        reg_idx_t               rt;
        reg_idx_t               dest;
        logic                   write_en;
        logic                   use_imm;
        word_t                  imm;
        logic [shamt_width-1:0] shamt;
    } decoded_t;

    // retiring result that also feeds the register file write port
    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- verilog/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  mips_pkg::word_t instr,
    output mips_pkg::wb_t   wb
);
    import mips_pkg::*;

    decoded_t dec;
    word_t    rs_data;
    word_t    rt_data;

    instr_decode instr_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    // write port is fed back from write-back
    register_file register_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs_idx      (dec.rs),
        .rt_idx      (dec.rt),
        .wb          (wb),
        .rs_data     (rs_data),
        .rt_data     (rt_data)
    );

    execute_unit execute_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wb          (wb)
    );

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::wb_t      wb,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data
);
    import mips_pkg::*;

    word_t regs [reg_count];

    // entry 0 stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // write-through for a same-cycle write
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wb.valid && wb.idx == idx)
            return wb.data;
        else
            return regs[idx];
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    no_write_to_zero: assert property (
        @(posedge clk) disable iff (!rst_n) wb.valid |-> wb.idx != '0
    );

endmodule

`default_nettype wire
